// File: verilog/ex_defs.svh
// widths and encodings shared by the execute stage RTL and its testbench, include where needed
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath
`define XLEN        32
`define INST_W      32
`define REG_AW      5

// instruction fields
`define OPC_W       7
`define F3_W        3

// funct7 of the M extension
`define F7_MULDIV   7'b0000001

// one quotient bit per cycle
`define DIV_STEPS   `XLEN

`endif

// File: verilog/ex_pkg.sv
// opcode and funct3 enums plus the packed buses between the execute stage blocks
`include "ex_defs.svh"

package ex_pkg;

    typedef enum logic [`OPC_W-1:0] {
        OPC_NOP    = 7'b0000001,
        OPC_LOAD   = 7'b0000011,
        OPC_FENCE  = 7'b0001111,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [`F3_W-1:0] {
        ALU_ADD  = 3'b000,  // add or sub
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,  // srl or sra
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [`F3_W-1:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_f3_e;

    typedef enum logic [`F3_W-1:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_f3_e;

    typedef enum logic [`F3_W-1:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_f3_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        DIV_CALC = 2'b01,
        DIV_DONE = 2'b10
    } div_state_e;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } reg_wb_t;

    typedef struct packed {
        logic             req;
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic             hold;
        logic             jump;
        logic [`XLEN-1:0] jump_addr;
    } flow_t;

    typedef struct packed {
        logic               start;
        md_f3_e             op;
        logic [`XLEN-1:0]   dividend;
        logic [`XLEN-1:0]   divisor;
        logic [`REG_AW-1:0] rd;
    } div_req_t;

    typedef struct packed {
        logic               busy;
        logic               ready;   // one cycle, result valid
        logic [`XLEN-1:0]   result;
        logic [`REG_AW-1:0] rd;
    } div_rsp_t;

endpackage

// File: verilog/alu.sv
// combinational integer ALU for OP and OP_IMM, also gives the compares used by branches
`timescale 1ns/10ps
`include "ex_defs.svh"

module alu import ex_pkg::*; (
    input  logic [`XLEN-1:0] op1_i,
    input  logic [`XLEN-1:0] op2_i,
    input  logic [`XLEN-1:0] reg1_rdata_i,
    input  logic [`XLEN-1:0] reg2_rdata_i,
    input  alu_f3_e          f3_i,
    input  logic             alt_i,        // inst bit 30
    input  logic             imm_form_i,
    input  logic [4:0]       shamt_i,
    output logic [`XLEN-1:0] result_o,
    output logic             lt_o,
    output logic             ltu_o,
    output logic             eq_o
);

    logic [4:0]       sh;
    logic [`XLEN-1:0] srl_res;
    logic [`XLEN-1:0] sr_mask;
    logic [`XLEN-1:0] sra_res;
    logic             do_sub;

    // shift amount from the immediate or from rs2
    assign sh = imm_form_i ? shamt_i : reg2_rdata_i[4:0];

    assign srl_res = reg1_rdata_i >> sh;
    assign sr_mask = {`XLEN{1'b1}} >> sh;
    // sign fill into the bits the mask clears
    assign sra_res = srl_res | ({`XLEN{reg1_rdata_i[`XLEN-1]}} & ~sr_mask);

    assign lt_o  = $signed(op1_i) < $signed(op2_i);
    assign ltu_o = op1_i < op2_i;
    assign eq_o  = (op1_i == op2_i);

    assign do_sub = alt_i && !imm_form_i;   // addi has no sub form

    always_comb begin
        case (f3_i)
            ALU_ADD: begin
                result_o = do_sub ? (op1_i - op2_i) : (op1_i + op2_i);
            end
            ALU_SLL: begin
                result_o = reg1_rdata_i << sh;
            end
            ALU_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, lt_o};
            end
            ALU_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, ltu_o};
            end
            ALU_XOR: begin
                result_o = op1_i ^ op2_i;
            end
            ALU_SR: begin
                result_o = alt_i ? sra_res : srl_res;
            end
            ALU_OR: begin
                result_o = op1_i | op2_i;
            end
            default: begin
                result_o = op1_i & op2_i;
            end
        endcase
    end

endmodule

// File: verilog/mul_unit.sv
// combinational 32x32 multiplier for MUL, MULH, MULHSU and MULHU, used by the execute stage
`timescale 1ns/10ps
`include "ex_defs.svh"

module mul_unit import ex_pkg::*; (
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    input  md_f3_e           f3_i,
    output logic [`XLEN-1:0] result_o
);

    logic                     a_signed;
    logic                     b_signed;
    logic                     a_neg;
    logic                     b_neg;
    logic [`XLEN-1:0]         a_mag;
    logic [`XLEN-1:0]         b_mag;
    logic [2*`XLEN-1:0]       prod;
    logic [2*`XLEN-1:0]       prod_fix;

    // low half of mul is the same for any signedness
    assign a_signed = (f3_i == MD_MUL) || (f3_i == MD_MULH) || (f3_i == MD_MULHSU);
    assign b_signed = (f3_i == MD_MUL) || (f3_i == MD_MULH);

    assign a_neg = a_signed && a_i[`XLEN-1];
    assign b_neg = b_signed && b_i[`XLEN-1];

    assign a_mag = a_neg ? (~a_i + 1'b1) : a_i;
    assign b_mag = b_neg ? (~b_i + 1'b1) : b_i;

    assign prod     = a_mag * b_mag;   // unsigned magnitudes
    assign prod_fix = (a_neg ^ b_neg) ? (~prod + 1'b1) : prod;

    assign result_o = (f3_i == MD_MUL) ? prod_fix[`XLEN-1:0] : prod_fix[2*`XLEN-1:`XLEN];

endmodule

// File: verilog/div_unit.sv
// iterative restoring divider for DIV, DIVU, REM and REMU, started and drained by the execute stage
`timescale 1ns/10ps
`include "ex_defs.svh"

module div_unit import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  div_req_t req_i,
    output div_rsp_t rsp_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS);

    div_state_e         state;
    logic [CNT_W-1:0]   cnt;
    md_f3_e             op_q;
    logic [`REG_AW-1:0] rd_q;
    logic [`XLEN-1:0]   dividend_q;   // as issued, for divide by zero
    logic [`XLEN-1:0]   divisor_q;    // magnitude
    logic [`XLEN-1:0]   quo_q;
    logic [`XLEN-1:0]   rem_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               by_zero_q;

    logic               is_signed;
    logic               accept;
    logic               done;
    logic [`XLEN:0]     trial;
    logic [`XLEN:0]     diff;
    logic [`XLEN-1:0]   quo_fix;
    logic [`XLEN-1:0]   rem_fix;
    logic [`XLEN-1:0]   result;

    assign is_signed = (req_i.op == MD_DIV) || (req_i.op == MD_REM);
    assign accept    = (state == DIV_IDLE) && req_i.start;
    assign done      = (state == DIV_DONE);

    // shift next dividend bit into the partial remainder, try to subtract
    assign trial = {rem_q, quo_q[`XLEN-1]};
    assign diff  = trial - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    cnt <= '0;
                    if (req_i.start) begin
                        state <= DIV_CALC;
                    end
                end
                DIV_CALC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;   // done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= req_i.op;
            rd_q       <= req_i.rd;
            dividend_q <= req_i.dividend;
            divisor_q  <= (is_signed && req_i.divisor[`XLEN-1]) ? (~req_i.divisor + 1'b1)
                                                                 : req_i.divisor;
            quo_q      <= (is_signed && req_i.dividend[`XLEN-1]) ? (~req_i.dividend + 1'b1)
                                                                 : req_i.dividend;
            rem_q      <= '0;
            neg_quo_q  <= is_signed && (req_i.dividend[`XLEN-1] ^ req_i.divisor[`XLEN-1]);
            neg_rem_q  <= is_signed && req_i.dividend[`XLEN-1];
            by_zero_q  <= (req_i.divisor == '0);
        end else if (state == DIV_CALC) begin
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= trial[`XLEN-1:0];   // restore
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    // most negative / -1 falls out of the magnitude path as dividend, rem 0
    always_comb begin
        quo_fix = neg_quo_q ? (~quo_q + 1'b1) : quo_q;
        rem_fix = neg_rem_q ? (~rem_q + 1'b1) : rem_q;
        if (by_zero_q) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end
        if ((op_q == MD_DIV) || (op_q == MD_DIVU)) begin
            result = quo_fix;
        end else begin
            result = rem_fix;
        end
    end

    assign rsp_o.busy   = (state == DIV_CALC);
    assign rsp_o.ready  = done;
    assign rsp_o.result = done ? result : '0;
    assign rsp_o.rd     = done ? rd_q : '0;

endmodule

// File: verilog/lsu_align.sv
// byte lane steering for the execute stage, extends loads and merges stores into the read word
`timescale 1ns/10ps
`include "ex_defs.svh"

module lsu_align import ex_pkg::*; (
    input  mem_f3_e          f3_i,
    input  logic [1:0]       offset_i,
    input  logic [`XLEN-1:0] rdata_i,
    input  logic [`XLEN-1:0] store_data_i,
    output logic [`XLEN-1:0] load_data_o,
    output logic [`XLEN-1:0] store_word_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = rdata_i[{offset_i, 3'b000} +: 8];
    assign half_lane = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];   // halfword aligned

    always_comb begin
        case (f3_i)
            MEM_B: begin
                load_data_o = {{(`XLEN-8){byte_lane[7]}}, byte_lane};
            end
            MEM_BU: begin
                load_data_o = {{(`XLEN-8){1'b0}}, byte_lane};
            end
            MEM_H: begin
                load_data_o = {{(`XLEN-16){half_lane[15]}}, half_lane};
            end
            MEM_HU: begin
                load_data_o = {{(`XLEN-16){1'b0}}, half_lane};
            end
            default: begin
                load_data_o = rdata_i;
            end
        endcase
    end

    // other lanes keep what memory returned
    always_comb begin
        store_word_o = rdata_i;
        case (f3_i)
            MEM_B: begin
                store_word_o[{offset_i, 3'b000} +: 8] = store_data_i[7:0];
            end
            MEM_H: begin
                store_word_o[{offset_i[1], 4'b0000} +: 16] = store_data_i[15:0];
            end
            default: begin
                store_word_o = store_data_i;   // full word
            end
        endcase
    end

endmodule

// File: verilog/ex.sv
// execute stage top, one instruction per cycle, drives write-back, memory request and fetch control
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex import ex_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [`INST_W-1:0] inst_i,
    input  logic [`XLEN-1:0]   inst_addr_i,
    input  logic               reg_we_i,
    input  logic [`XLEN-1:0]   reg1_rdata_i,
    input  logic [`XLEN-1:0]   reg2_rdata_i,
    input  logic [`XLEN-1:0]   op1_i,
    input  logic [`XLEN-1:0]   op2_i,
    input  logic [`XLEN-1:0]   op1_jump_i,
    input  logic [`XLEN-1:0]   op2_jump_i,
    input  logic [`XLEN-1:0]   mem_rdata_i,
    output reg_wb_t            wb_o,
    output mem_req_t           mem_o,
    output flow_t              flow_o
);

    opcode_e            opcode;
    logic [`F3_W-1:0]   funct3;
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rd;
    logic               is_md;
    logic               is_div;
    logic               is_load;
    logic               is_store;
    logic               no_wb;
    logic               br_taken;
    logic               lt;
    logic               ltu;
    logic               eq;
    logic [`XLEN-1:0]   add_res;
    logic [`XLEN-1:0]   jump_sum;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   mul_res;
    logic [`XLEN-1:0]   load_data;
    logic [`XLEN-1:0]   store_word;
    logic [`XLEN-1:0]   wb_data;
    div_req_t           div_req;
    div_rsp_t           div_rsp;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    assign is_md    = (opcode == OPC_OP) && (funct7 == `F7_MULDIV);
    assign is_div   = is_md && funct3[2];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    assign add_res  = op1_i + op2_i;   // mem address, link, lui/auipc
    assign jump_sum = op1_jump_i + op2_jump_i;

    alu alu_i (
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .reg1_rdata_i (reg1_rdata_i),
        .reg2_rdata_i (reg2_rdata_i),
        .f3_i         (alu_f3_e'(funct3)),
        .alt_i        (inst_i[30]),
        .imm_form_i   (opcode == OPC_OP_IMM),
        .shamt_i      (inst_i[24:20]),
        .result_o     (alu_res),
        .lt_o         (lt),
        .ltu_o        (ltu),
        .eq_o         (eq)
    );

    mul_unit mul_i (
        .a_i      (reg1_rdata_i),
        .b_i      (reg2_rdata_i),
        .f3_i     (md_f3_e'(funct3)),
        .result_o (mul_res)
    );

    lsu_align lsu_i (
        .f3_i         (mem_f3_e'(funct3)),
        .offset_i     (add_res[1:0]),
        .rdata_i      (mem_rdata_i),
        .store_data_i (reg2_rdata_i),
        .load_data_o  (load_data),
        .store_word_o (store_word)
    );

    assign div_req.start    = is_div;   // unit ignores it unless idle
    assign div_req.op       = md_f3_e'(funct3);
    assign div_req.dividend = reg1_rdata_i;
    assign div_req.divisor  = reg2_rdata_i;
    assign div_req.rd       = rd;

    div_unit div_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (div_req),
        .rsp_o   (div_rsp)
    );

    always_comb begin
        case (br_f3_e'(funct3))
            BR_EQ:   br_taken = eq;
            BR_NE:   br_taken = !eq;
            BR_LT:   br_taken = lt;
            BR_GE:   br_taken = !lt;
            BR_LTU:  br_taken = ltu;
            BR_GEU:  br_taken = !ltu;
            default: br_taken = 1'b0;
        endcase
        br_taken = br_taken && (opcode == OPC_BRANCH);
    end

    always_comb begin
        case (opcode)
            OPC_OP_IMM: wb_data = alu_res;
            OPC_OP:     wb_data = is_md ? (is_div ? '0 : mul_res) : alu_res;
            OPC_LOAD:   wb_data = load_data;
            OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: begin
                wb_data = add_res;
            end
            default:    wb_data = '0;
        endcase
    end

    assign no_wb = is_store || (opcode == OPC_BRANCH) || (opcode == OPC_FENCE) || is_div;

    always_comb begin
        wb_o.we    = reg_we_i && !no_wb;
        wb_o.waddr = rd;
        wb_o.wdata = wb_data;
        if (div_rsp.ready) begin   // divide completion wins
            wb_o.we    = 1'b1;
            wb_o.waddr = div_rsp.rd;
            wb_o.wdata = div_rsp.result;
        end
    end

    assign mem_o.req   = is_load || is_store;
    assign mem_o.we    = is_store;
    assign mem_o.addr  = mem_o.req ? add_res : '0;
    assign mem_o.wdata = is_store ? store_word : '0;

    // divide re-fetches from the jump target once it completes
    assign flow_o.hold      = is_div || div_rsp.busy;
    assign flow_o.jump      = br_taken || (opcode == OPC_JAL) || (opcode == OPC_JALR)
                              || (opcode == OPC_FENCE) || is_div;
    assign flow_o.jump_addr = flow_o.jump ? jump_sum : inst_addr_i;   // no redirect, echo pc

endmodule

// File: tests/tb_ex.sv
// testbench for the execute stage, replays the vectors in tests/ex_stim.txt and checks every output
`timescale 1ns/10ps
`include "ex_defs.svh"

module tb_ex import ex_pkg::*; ();

    // one line of the stimulus file
    typedef struct packed {
        logic [31:0]        kind;   // tag text, right aligned
        logic [`INST_W-1:0] inst;
        logic               reg_we;
        logic [`XLEN-1:0]   reg1;
        logic [`XLEN-1:0]   reg2;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;
        logic [`XLEN-1:0]   op1_jump;
        logic [`XLEN-1:0]   op2_jump;
        logic [`XLEN-1:0]   mem_rdata;
        logic               exp_we;
        logic [`XLEN-1:0]   exp_wdata;
        logic               exp_req;
        logic               exp_mem_we;
        logic [`XLEN-1:0]   exp_addr;
        logic [`XLEN-1:0]   exp_mem_wdata;
        logic               exp_hold;
        logic               exp_jump;
        logic [`XLEN-1:0]   exp_jump_addr;
    } vec_t;

    logic               clk;
    logic               rst_n;
    logic [`INST_W-1:0] inst;
    logic [`XLEN-1:0]   inst_addr;
    logic               reg_we;
    logic [`XLEN-1:0]   reg1_rdata;
    logic [`XLEN-1:0]   reg2_rdata;
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   op1_jump;
    logic [`XLEN-1:0]   op2_jump;
    logic [`XLEN-1:0]   mem_rdata;
    reg_wb_t            wb;
    mem_req_t           mem;
    flow_t              flow;

    vec_t vecs[$];
    int   errors;
    int   failed_tests;
    int   cycles;
    int   cycle_limit;

    ex dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .inst_addr_i  (inst_addr),
        .reg_we_i     (reg_we),
        .reg1_rdata_i (reg1_rdata),
        .reg2_rdata_i (reg2_rdata),
        .op1_i        (op1),
        .op2_i        (op2),
        .op1_jump_i   (op1_jump),
        .op2_jump_i   (op2_jump),
        .mem_rdata_i  (mem_rdata),
        .wb_o         (wb),
        .mem_o        (mem),
        .flow_o       (flow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped after %0d clock cycles without finishing the vectors", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [`XLEN-1:0] got,
                         input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_inputs();
        inst       = {{(`INST_W-7){1'b0}}, OPC_NOP};
        inst_addr  = '0;
        reg_we     = 1'b0;
        reg1_rdata = '0;
        reg2_rdata = '0;
        op1        = '0;
        op2        = '0;
        op1_jump   = '0;
        op2_jump   = '0;
        mem_rdata  = '0;
    endtask

    task automatic apply_inputs(input vec_t v);
        inst       = v.inst;
        inst_addr  = v.op1_jump;   // pc
        reg_we     = v.reg_we;
        reg1_rdata = v.reg1;
        reg2_rdata = v.reg2;
        op1        = v.op1;
        op2        = v.op2;
        op1_jump   = v.op1_jump;
        op2_jump   = v.op2_jump;
        mem_rdata  = v.mem_rdata;
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 n;
        logic [31:0]        tag;
        logic [31:0]        c[18];
        logic [8*128-1:0]   rest;
        vec_t               v;
        fd = $fopen("tests/ex_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/ex_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n == 1 && tag == "#") begin
                    n = $fgets(rest, fd);   // column notes
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8],
                                c[9], c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17]);
                    if (n == 18) begin
                        v = {tag, c[0], c[1][0], c[2], c[3], c[4], c[5], c[6], c[7], c[8],
                             c[9][0], c[10], c[11][0], c[12][0], c[13], c[14],
                             c[15][0], c[16][0], c[17]};
                        vecs.push_back(v);
                    end else begin
                        $display("stimulus line after vector %0d is malformed", vecs.size());
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vector(input int idx, input vec_t v);
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        apply_inputs(v);
        @(negedge clk);
        check("flow_o.hold", flow.hold, v.exp_hold);
        check("flow_o.jump", flow.jump, v.exp_jump);
        if (v.exp_jump) begin
            check("flow_o.jump_addr", flow.jump_addr, v.exp_jump_addr);
        end
        check("mem_o.req", mem.req, v.exp_req);
        check("mem_o.we", mem.we, v.exp_mem_we);
        if (v.exp_req) begin
            check("mem_o.addr", mem.addr, v.exp_addr);
        end
        if (v.exp_mem_we) begin
            check("mem_o.wdata", mem.wdata, v.exp_mem_wdata);
        end
        if (v.kind == "div") begin
            check("wb_o.we", wb.we, 1'b0);   // nothing written at issue
            @(posedge clk);
            #1;
            idle_inputs();
            @(negedge clk);
            while (wb.we !== 1'b1) begin
                check("flow_o.hold", flow.hold, 1'b1);
                @(negedge clk);
            end
        end
        check("wb_o.we", wb.we, v.exp_we);
        if (v.exp_we) begin
            check("wb_o.waddr", wb.waddr, v.inst[11:7]);   // rd field
            check("wb_o.wdata", wb.wdata, v.exp_wdata);
        end
        if (errors == errs_before) begin
            $display("test %0d inst %h ok", idx + 1, v.inst);
        end else begin
            $display("test %0d inst %h failed", idx + 1, v.inst);
            failed_tests++;
        end
    endtask

    initial begin
        errors       = 0;
        failed_tests = 0;
        cycles       = 0;
        cycle_limit  = 0;
        rst_n        = 1'b0;
        idle_inputs();
        load_vectors();
        if (vecs.size() == 0) begin
            $display("no stimulus vectors were read");
            errors++;
        end
        cycle_limit = vecs.size() * 40 + 16;   // reset cycles on top
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (vecs[i]) begin
            run_vector(i, vecs[i]);
        end
        $display("%0d tests run, %0d failed, %0d check errors",
                 vecs.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/ex_stim.txt
# kind inst reg_we reg1 reg2 op1 op2 op1_jump op2_jump mem_rdata, then expected values:
# we wdata req mem_we addr mem_wdata hold jump jump_addr, all hex
nop 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
alu 2b3 1 7 10 7 10 0 0 0 1 17 0 0 0 0 0 0 0
alu 2b3 0 7 10 7 10 0 0 0 0 17 0 0 0 0 0 0 0
alu 400002b3 1 5 7 5 7 0 0 0 1 fffffffe 0 0 0 0 0 0 0
alu 40000293 1 10 0 10 400 0 0 0 1 410 0 0 0 0 0 0 0
alu 12b3 1 3 21 3 21 0 0 0 1 6 0 0 0 0 0 0 0
alu 401293 1 12345678 0 12345678 4 0 0 0 1 23456780 0 0 0 0 0 0 0
alu 22b3 1 ffffffff 1 ffffffff 1 0 0 0 1 1 0 0 0 0 0 0 0
alu 32b3 1 ffffffff 1 ffffffff 1 0 0 0 1 0 0 0 0 0 0 0 0
alu ff04293 1 f0f0f0f 0 f0f0f0f ff 0 0 0 1 f0f0ff0 0 0 0 0 0 0 0
alu 62b3 1 f0 f00 f0 f00 0 0 0 1 ff0 0 0 0 0 0 0 0
alu f007293 1 12345678 0 12345678 f0 0 0 0 1 70 0 0 0 0 0 0 0
alu 400052b3 1 80000010 4 80000010 4 0 0 0 1 f8000001 0 0 0 0 0 0 0
alu 40805293 1 f0001234 0 f0001234 408 0 0 0 1 fff00012 0 0 0 0 0 0 0
alu 805293 1 f0001234 0 f0001234 8 0 0 0 1 f00012 0 0 0 0 0 0 0
alu 123452b7 1 0 0 12345000 0 0 0 0 1 12345000 0 0 0 0 0 0 0
alu 1297 1 0 0 400 1000 0 0 0 1 1400 0 0 0 0 0 0 0
mul 20002b3 1 fffffffe 3 fffffffe 3 0 0 0 1 fffffffa 0 0 0 0 0 0 0
mul 20012b3 1 80000000 3 80000000 3 0 0 0 1 fffffffe 0 0 0 0 0 0 0
mul 20022b3 1 ffffffff ffffffff ffffffff ffffffff 0 0 0 1 ffffffff 0 0 0 0 0 0 0
mul 20032b3 1 ffffffff ffffffff ffffffff ffffffff 0 0 0 1 fffffffe 0 0 0 0 0 0 0
ld 283 1 0 0 1000 0 0 0 81f27384 1 ffffff84 1 0 1000 0 0 0 0
ld 283 1 0 0 1000 1 0 0 81f27384 1 73 1 0 1001 0 0 0 0
ld 283 1 0 0 1000 2 0 0 81f27384 1 fffffff2 1 0 1002 0 0 0 0
ld 283 1 0 0 1000 3 0 0 81f27384 1 ffffff81 1 0 1003 0 0 0 0
ld 4283 1 0 0 1000 0 0 0 81f27384 1 84 1 0 1000 0 0 0 0
ld 4283 1 0 0 1000 1 0 0 81f27384 1 73 1 0 1001 0 0 0 0
ld 4283 1 0 0 1000 2 0 0 81f27384 1 f2 1 0 1002 0 0 0 0
ld 4283 1 0 0 1000 3 0 0 81f27384 1 81 1 0 1003 0 0 0 0
ld 1283 1 0 0 1000 0 0 0 81f27384 1 7384 1 0 1000 0 0 0 0
ld 1283 1 0 0 1000 2 0 0 81f27384 1 ffff81f2 1 0 1002 0 0 0 0
ld 5283 1 0 0 1000 0 0 0 81f27384 1 7384 1 0 1000 0 0 0 0
ld 5283 1 0 0 1000 2 0 0 81f27384 1 81f2 1 0 1002 0 0 0 0
ld 2283 1 0 0 1000 0 0 0 81f27384 1 81f27384 1 0 1000 0 0 0 0
st 23 1 0 cafe55aa 2000 2 0 0 81f27384 0 0 1 1 2002 81aa7384 0 0 0
st 1023 1 0 cafe55aa 2000 2 0 0 81f27384 0 0 1 1 2002 55aa7384 0 0 0
st 2023 1 0 cafe55aa 2000 0 0 0 81f27384 0 0 1 1 2000 cafe55aa 0 0 0
br 63 0 5 5 5 5 100 20 0 0 0 0 0 0 0 0 1 120
br 63 0 5 6 5 6 100 20 0 0 0 0 0 0 0 0 0 0
br 1063 0 5 6 5 6 100 20 0 0 0 0 0 0 0 0 1 120
br 1063 0 5 5 5 5 100 20 0 0 0 0 0 0 0 0 0 0
br 4063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0 1 120
br 4063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0 0 0
br 5063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0 1 120
br 5063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0 0 0
br 6063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0 1 120
br 6063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0 0 0
br 7063 0 ffffffff 1 ffffffff 1 100 20 0 0 0 0 0 0 0 0 1 120
br 7063 0 1 ffffffff 1 ffffffff 100 20 0 0 0 0 0 0 0 0 0 0
jmp ef 1 0 0 100 4 100 40 0 1 104 0 0 0 0 0 1 140
jmp e7 1 3000 0 200 4 3000 10 0 1 204 0 0 0 0 0 1 3010
jmp f 1 0 0 0 0 300 4 0 0 0 0 0 0 0 0 1 304
div 20043b3 1 ffffffe9 5 ffffffe9 5 400 4 0 1 fffffffc 0 0 0 0 1 1 404
div 20053b3 1 64 7 64 7 400 4 0 1 e 0 0 0 0 1 1 404
div 20063b3 1 ffffffe9 5 ffffffe9 5 400 4 0 1 fffffffd 0 0 0 0 1 1 404
div 20073b3 1 64 7 64 7 400 4 0 1 2 0 0 0 0 1 1 404
div 20043b3 1 1234 0 1234 0 400 4 0 1 ffffffff 0 0 0 0 1 1 404
div 20063b3 1 1234 0 1234 0 400 4 0 1 1234 0 0 0 0 1 1 404
div 20043b3 1 80000000 ffffffff 80000000 ffffffff 400 4 0 1 80000000 0 0 0 0 1 1 404
div 20063b3 1 80000000 ffffffff 80000000 ffffffff 400 4 0 1 0 0 0 0 0 1 1 404

// File: flist.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/lsu_align.sv
verilog/ex.sv
tests/tb_ex.sv

// File: run.sh
#!/bin/sh
# compile the execute stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ex -f flist.f -o tb_ex || exit 1
out=$(./obj_dir/tb_ex)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && exit 0 || exit 1
